//--- Bender.yml
package:
  name: mips_control_unit

sources:
  - src/mipsCtrlPkg.sv
  - src/aluCtrlDecoder.sv
  - src/memCtrlDecoder.sv
  - src/flowCtrlDecoder.sv
  - src/writebackCtrlDecoder.sv
  - src/controlUnit.sv
  - target: test
    files:
      - dv/tbClockGen.sv
      - dv/controlUnitTb.sv

//--- compile.f
src/mipsCtrlPkg.sv
src/aluCtrlDecoder.sv
src/memCtrlDecoder.sv
src/flowCtrlDecoder.sv
src/writebackCtrlDecoder.sv
src/controlUnit.sv
dv/tbClockGen.sv
dv/controlUnitTb.sv

//--- dv/controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb;

    localparam int numInstr   = 400;
    localparam int cycleLimit = numInstr * 2 + 100; // Every other cycle a gap, plus reset and drain

    localparam logic [5:0] opTable [24] = '{
        mipsCtrlPkg::OP_RTYPE, mipsCtrlPkg::OP_REGIMM, mipsCtrlPkg::OP_J, mipsCtrlPkg::OP_JAL,
        mipsCtrlPkg::OP_BEQ, mipsCtrlPkg::OP_BNE, mipsCtrlPkg::OP_BLEZ, mipsCtrlPkg::OP_BGTZ,
        mipsCtrlPkg::OP_ADDI, mipsCtrlPkg::OP_ADDIU, mipsCtrlPkg::OP_SLTI, mipsCtrlPkg::OP_SLTIU,
        mipsCtrlPkg::OP_ANDI, mipsCtrlPkg::OP_ORI, mipsCtrlPkg::OP_XORI, mipsCtrlPkg::OP_LUI,
        mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH, mipsCtrlPkg::OP_LW, mipsCtrlPkg::OP_LBU,
        mipsCtrlPkg::OP_LHU, mipsCtrlPkg::OP_SB, mipsCtrlPkg::OP_SH, mipsCtrlPkg::OP_SW
    };
    localparam logic [5:0] fnTable [15] = '{
        mipsCtrlPkg::FN_SLL, mipsCtrlPkg::FN_SRL, mipsCtrlPkg::FN_SRA, mipsCtrlPkg::FN_JR,
        mipsCtrlPkg::FN_JALR, mipsCtrlPkg::FN_ADD, mipsCtrlPkg::FN_ADDU, mipsCtrlPkg::FN_SUB,
        mipsCtrlPkg::FN_SUBU, mipsCtrlPkg::FN_AND, mipsCtrlPkg::FN_OR, mipsCtrlPkg::FN_XOR,
        mipsCtrlPkg::FN_NOR, mipsCtrlPkg::FN_SLT, mipsCtrlPkg::FN_SLTU
    };

    logic                               clk;
    logic                               rstN;
    logic                               instrValid;
    logic [mipsCtrlPkg::instrWidth-1:0] instr;
    logic                               ctrlValid;
    mipsCtrlPkg::ctrlWord_t             ctrl;

    mipsCtrlPkg::ctrlWord_t expQ [$]; // Words in flight, oldest first
    mipsCtrlPkg::ctrlWord_t lastExp;  // What ctrl must hold in a gap
    logic [31:0]            rngState = 32'd32;
    int                     issued   = 0;
    int                     compared = 0;
    int                     cycleCount = 0;

    tbClockGen clkGen (.clk(clk), .rstN(rstN));

    controlUnit dut (
        .clk       (clk),
        .rstN      (rstN),
        .instrValid(instrValid),
        .instr     (instr),
        .ctrlValid (ctrlValid),
        .ctrl      (ctrl)
    );

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13); // xorshift32
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic bit isDefinedOp(input logic [5:0] op);
        bit found;
        found = 1'b0;
        foreach (opTable[i]) begin
            if (opTable[i] == op) found = 1'b1;
        end
        return found;
    endfunction

    function automatic logic [31:0] makeInstr();
        logic [31:0] ins;
        logic [31:0] pick;
        logic [5:0]  op;
        ins  = nextRand(); // Random filler in every field
        pick = nextRand();
        if (pick % 10 == 0) begin
            op = ins[31:26];
            while (isDefinedOp(op)) begin
                op = op + 6'd1; // Walk to the next hole in the map
            end
            ins[31:26] = op;
        end else begin
            ins[31:26] = opTable[int'(pick[15:8]) % 24];
            if (ins[31:26] == mipsCtrlPkg::OP_RTYPE)
                ins[5:0] = fnTable[int'(pick[23:16]) % 15];
            if (ins[31:26] == mipsCtrlPkg::OP_REGIMM) begin
                case (pick[25:24])
                    2'd0:    ins[20:16] = 5'd0; // BLTZ
                    2'd1:    ins[20:16] = 5'd1; // BGEZ
                    default: ;                  // Odd rt, must fall back to BLTZ
                endcase
            end
        end
        return ins;
    endfunction

    // ==============================
    // Reference decode
    // ==============================
    function automatic mipsCtrlPkg::ctrlWord_t expectedCtrl(input logic [31:0] ins);
        mipsCtrlPkg::ctrlWord_t w;
        logic [5:0] op;
        logic [5:0] fn;
        op = ins[31:26];
        fn = ins[5:0];
        w  = '0;
        w.mem.memSize = mipsCtrlPkg::SIZE_WORD; // Only non-zero NOP field
        case (op)
            mipsCtrlPkg::OP_RTYPE: begin
                w.alu.aluOp    = mipsCtrlPkg::aluOp_e'(fn);
                w.alu.aluShift = (fn == mipsCtrlPkg::FN_SLL) || (fn == mipsCtrlPkg::FN_SRL) ||
                                 (fn == mipsCtrlPkg::FN_SRA);
                w.flow.jumpReg = (fn == mipsCtrlPkg::FN_JR) || (fn == mipsCtrlPkg::FN_JALR);
                if (w.flow.jumpReg) w.alu.aluOp = mipsCtrlPkg::ALU_JR;
                if (fn != mipsCtrlPkg::FN_JR) begin
                    w.wb.regWrite = 1'b1;
                    w.wb.regDst   = mipsCtrlPkg::DST_RD;
                end
                if (fn == mipsCtrlPkg::FN_JALR) w.wb.wbSel = mipsCtrlPkg::WB_PC4;
            end
            mipsCtrlPkg::OP_ADDI, mipsCtrlPkg::OP_ADDIU, mipsCtrlPkg::OP_SLTI,
            mipsCtrlPkg::OP_SLTIU, mipsCtrlPkg::OP_ANDI, mipsCtrlPkg::OP_ORI,
            mipsCtrlPkg::OP_XORI, mipsCtrlPkg::OP_LUI: begin
                w.alu.aluSrc     = 1'b1;
                w.alu.zeroExtend = op[2]; // 0x0c..0x0f are the logical ones
                w.alu.lui        = (op == mipsCtrlPkg::OP_LUI);
                w.wb.regWrite    = 1'b1;  // rt, ALU result
                case (op[2:0])
                    3'd0:    w.alu.aluOp = mipsCtrlPkg::ALU_ADD;
                    3'd1:    w.alu.aluOp = mipsCtrlPkg::ALU_ADDU;
                    3'd2:    w.alu.aluOp = mipsCtrlPkg::ALU_SLT;
                    3'd3:    w.alu.aluOp = mipsCtrlPkg::ALU_SLTU;
                    3'd4:    w.alu.aluOp = mipsCtrlPkg::ALU_AND;
                    3'd6:    w.alu.aluOp = mipsCtrlPkg::ALU_XOR;
                    default: w.alu.aluOp = mipsCtrlPkg::ALU_OR; // ORI, LUI
                endcase
            end
            mipsCtrlPkg::OP_LW, mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH,
            mipsCtrlPkg::OP_LBU, mipsCtrlPkg::OP_LHU: begin
                w.alu.aluOp       = mipsCtrlPkg::ALU_ADD;
                w.alu.aluSrc      = 1'b1;
                w.mem.memRead     = 1'b1;
                w.mem.loadExtend  = (op != mipsCtrlPkg::OP_LW);
                w.wb.regWrite     = 1'b1;
                w.wb.wbSel        = mipsCtrlPkg::WB_MEM;
                if (op == mipsCtrlPkg::OP_LH)  w.mem.loadType = mipsCtrlPkg::LD_LH;
                if (op == mipsCtrlPkg::OP_LBU) w.mem.loadType = mipsCtrlPkg::LD_LBU;
                if (op == mipsCtrlPkg::OP_LHU) w.mem.loadType = mipsCtrlPkg::LD_LHU;
            end
            mipsCtrlPkg::OP_SW, mipsCtrlPkg::OP_SH, mipsCtrlPkg::OP_SB: begin
                w.alu.aluOp    = mipsCtrlPkg::ALU_ADD;
                w.alu.aluSrc   = 1'b1;
                w.mem.memWrite = 1'b1;
                if (op == mipsCtrlPkg::OP_SH) w.mem.memSize = mipsCtrlPkg::SIZE_HALF;
                if (op == mipsCtrlPkg::OP_SB) w.mem.memSize = mipsCtrlPkg::SIZE_BYTE;
            end
            mipsCtrlPkg::OP_BEQ, mipsCtrlPkg::OP_BNE, mipsCtrlPkg::OP_BLEZ,
            mipsCtrlPkg::OP_BGTZ, mipsCtrlPkg::OP_REGIMM: begin
                w.flow.branch = 1'b1;
                case (op)
                    mipsCtrlPkg::OP_BEQ:  w.alu.aluOp = mipsCtrlPkg::ALU_BEQ;
                    mipsCtrlPkg::OP_BNE:  w.alu.aluOp = mipsCtrlPkg::ALU_BNE;
                    mipsCtrlPkg::OP_BLEZ: w.alu.aluOp = mipsCtrlPkg::ALU_BLEZ;
                    mipsCtrlPkg::OP_BGTZ: w.alu.aluOp = mipsCtrlPkg::ALU_BGTZ;
                    default: w.alu.aluOp = (ins[20:16] == 5'd1) ? mipsCtrlPkg::ALU_BGEZ
                                                                : mipsCtrlPkg::ALU_BLTZ;
                endcase
            end
            mipsCtrlPkg::OP_J, mipsCtrlPkg::OP_JAL: begin
                w.alu.aluOp = mipsCtrlPkg::ALU_J;
                w.flow.jump = 1'b1;
                if (op == mipsCtrlPkg::OP_JAL) begin
                    w.wb.regWrite = 1'b1;
                    w.wb.regDst   = mipsCtrlPkg::DST_RA; // Link register
                    w.wb.wbSel    = mipsCtrlPkg::WB_PC4;
                end
            end
            default: ; // Hole in the opcode map
        endcase
        return w;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic reportMismatch(input string name, input logic [31:0] expV,
                                  input logic [31:0] actV);
        $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expV, actV);
        $display("Simulation failed");
        $fatal(1, "Control word mismatch");
    endtask

    task automatic checkValid(input logic exp, input logic act);
        if (exp !== act) reportMismatch("ctrlValid", exp, act);
    endtask

    task automatic checkAlu(input mipsCtrlPkg::aluCtrl_t exp, input mipsCtrlPkg::aluCtrl_t act);
        if (exp.aluOp !== act.aluOp) reportMismatch("ctrl.alu.aluOp", exp.aluOp, act.aluOp);
        if (exp.aluSrc !== act.aluSrc) reportMismatch("ctrl.alu.aluSrc", exp.aluSrc, act.aluSrc);
        if (exp.aluShift !== act.aluShift)
            reportMismatch("ctrl.alu.aluShift", exp.aluShift, act.aluShift);
        if (exp.zeroExtend !== act.zeroExtend)
            reportMismatch("ctrl.alu.zeroExtend", exp.zeroExtend, act.zeroExtend);
        if (exp.lui !== act.lui) reportMismatch("ctrl.alu.lui", exp.lui, act.lui);
    endtask

    task automatic checkMem(input mipsCtrlPkg::memCtrl_t exp, input mipsCtrlPkg::memCtrl_t act);
        if (exp.memRead !== act.memRead)
            reportMismatch("ctrl.mem.memRead", exp.memRead, act.memRead);
        if (exp.memWrite !== act.memWrite)
            reportMismatch("ctrl.mem.memWrite", exp.memWrite, act.memWrite);
        if (exp.memSize !== act.memSize)
            reportMismatch("ctrl.mem.memSize", exp.memSize, act.memSize);
        if (exp.loadType !== act.loadType)
            reportMismatch("ctrl.mem.loadType", exp.loadType, act.loadType);
        if (exp.loadExtend !== act.loadExtend)
            reportMismatch("ctrl.mem.loadExtend", exp.loadExtend, act.loadExtend);
    endtask

    task automatic checkFlow(input mipsCtrlPkg::flowCtrl_t exp,
                             input mipsCtrlPkg::flowCtrl_t act);
        if (exp.branch !== act.branch) reportMismatch("ctrl.flow.branch", exp.branch, act.branch);
        if (exp.jump !== act.jump) reportMismatch("ctrl.flow.jump", exp.jump, act.jump);
        if (exp.jumpReg !== act.jumpReg)
            reportMismatch("ctrl.flow.jumpReg", exp.jumpReg, act.jumpReg);
    endtask

    task automatic checkWb(input mipsCtrlPkg::wbCtrl_t exp, input mipsCtrlPkg::wbCtrl_t act);
        if (exp.regWrite !== act.regWrite)
            reportMismatch("ctrl.wb.regWrite", exp.regWrite, act.regWrite);
        if (exp.regDst !== act.regDst) reportMismatch("ctrl.wb.regDst", exp.regDst, act.regDst);
        if (exp.wbSel !== act.wbSel) reportMismatch("ctrl.wb.wbSel", exp.wbSel, act.wbSel);
    endtask

    // ==============================
    // Drive, track, compare
    // ==============================
    initial begin
        instrValid = 1'b0;
        instr      = '0;
        lastExp    = '0;
        lastExp.mem.memSize = mipsCtrlPkg::SIZE_WORD; // Reset word
        wait (rstN === 1'b1);
        @(posedge clk);
        while (issued < numInstr) begin
            #2;
            if (nextRand() % 4 == 0) begin
                instrValid = 1'b0;       // Gap
                instr      = nextRand(); // Junk that must not load
            end else begin
                instrValid = 1'b1;
                instr      = makeInstr();
                issued++;
            end
            @(posedge clk);
        end
        #2 instrValid = 1'b0;
        wait (compared == numInstr);
        repeat (2) @(negedge clk); // Last word must hold
        if (expQ.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d expected control words were never produced", expQ.size());
            $display("Simulation failed");
            $fatal(1, "Leftover words");
        end
    end

    // Capture at the edge that accepts the instruction
    always @(posedge clk) begin
        if (rstN && instrValid) expQ.push_back(expectedCtrl(instr));
    end

    // Mid-cycle sampling keeps clear of the edge
    always @(negedge clk) begin
        mipsCtrlPkg::ctrlWord_t exp;
        if (rstN) begin
            if (ctrlValid && expQ.size() == 0) begin
                $display("ctrlValid was high at %0t with no instruction outstanding", $time);
                $display("Simulation failed");
                $fatal(1, "Unexpected valid");
            end else begin
                checkValid(expQ.size() != 0, ctrlValid); // Word due one cycle after acceptance
                if (ctrlValid) begin
                    exp     = expQ.pop_front();
                    lastExp = exp;
                    compared++;
                end else begin
                    exp = lastExp; // Gap or idle after reset
                end
                checkAlu(exp.alu, ctrl.alu);
                checkMem(exp.mem, ctrl.mem);
                checkFlow(exp.flow, ctrl.flow);
                checkWb(exp.wb, ctrl.wb);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Run exceeded %0d cycles before all control words arrived", cycleLimit);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

endmodule

//--- dv/tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen (
    output logic clk,
    output logic rstN
);

    localparam time halfPeriod  = 20ns; // 40 ns clock
    localparam int  resetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 rstN = 1'b1;
    end

endmodule

//--- src/aluCtrlDecoder.sv
`timescale 1ns/100ps

module aluCtrlDecoder (
    input  mipsCtrlPkg::instrFields_t fields,
    output mipsCtrlPkg::aluCtrl_t     alu
);

    always_comb begin
        alu = mipsCtrlPkg::nopWord.alu; // Quiet unless decoded below

        case (fields.opcode)
            // ==============================
            // Register forms
            // ==============================
            mipsCtrlPkg::OP_RTYPE: begin
                case (fields.funct)
                    mipsCtrlPkg::FN_JR,
                    mipsCtrlPkg::FN_JALR: alu.aluOp = mipsCtrlPkg::ALU_JR; // Target check
                    mipsCtrlPkg::FN_SLL,
                    mipsCtrlPkg::FN_SRL,
                    mipsCtrlPkg::FN_SRA: begin
                        alu.aluOp    = mipsCtrlPkg::aluOp_e'(fields.funct); // Same code
                        alu.aluShift = 1'b1;                                // shamt on A
                    end
                    default: alu.aluOp = mipsCtrlPkg::aluOp_e'(fields.funct); // Pass-through
                endcase
            end

            // ==============================
            // Immediate forms
            // ==============================
            mipsCtrlPkg::OP_ADDI: begin
                alu.aluOp  = mipsCtrlPkg::ALU_ADD;
                alu.aluSrc = 1'b1;
            end
            mipsCtrlPkg::OP_ADDIU: begin
                alu.aluOp  = mipsCtrlPkg::ALU_ADDU; // Still sign-extends
                alu.aluSrc = 1'b1;
            end
            mipsCtrlPkg::OP_SLTI: begin
                alu.aluOp  = mipsCtrlPkg::ALU_SLT;
                alu.aluSrc = 1'b1;
            end
            mipsCtrlPkg::OP_SLTIU: begin
                alu.aluOp  = mipsCtrlPkg::ALU_SLTU;
                alu.aluSrc = 1'b1;
            end
            mipsCtrlPkg::OP_ANDI, mipsCtrlPkg::OP_ORI,
            mipsCtrlPkg::OP_XORI, mipsCtrlPkg::OP_LUI: begin
                alu.aluSrc     = 1'b1;
                alu.zeroExtend = 1'b1; // Logical imm
                case (fields.opcode)
                    mipsCtrlPkg::OP_ANDI: alu.aluOp = mipsCtrlPkg::ALU_AND;
                    mipsCtrlPkg::OP_XORI: alu.aluOp = mipsCtrlPkg::ALU_XOR;
                    default:              alu.aluOp = mipsCtrlPkg::ALU_OR; // ORI and LUI
                endcase
                alu.lui = (fields.opcode == mipsCtrlPkg::OP_LUI); // OR with zero after shift
            end

            // Address generation, base + offset
            mipsCtrlPkg::OP_LW, mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH,
            mipsCtrlPkg::OP_LBU, mipsCtrlPkg::OP_LHU,
            mipsCtrlPkg::OP_SW, mipsCtrlPkg::OP_SB, mipsCtrlPkg::OP_SH: begin
                alu.aluOp  = mipsCtrlPkg::ALU_ADD;
                alu.aluSrc = 1'b1;
            end

            // ==============================
            // Branches and jumps
            // ==============================
            mipsCtrlPkg::OP_BEQ:  alu.aluOp = mipsCtrlPkg::ALU_BEQ;
            mipsCtrlPkg::OP_BNE:  alu.aluOp = mipsCtrlPkg::ALU_BNE;
            mipsCtrlPkg::OP_BLEZ: alu.aluOp = mipsCtrlPkg::ALU_BLEZ;
            mipsCtrlPkg::OP_BGTZ: alu.aluOp = mipsCtrlPkg::ALU_BGTZ;
            mipsCtrlPkg::OP_REGIMM: begin
                if (fields.rt == mipsCtrlPkg::regAddrWidth'(1)) // BGEZ rt value
                    alu.aluOp = mipsCtrlPkg::ALU_BGEZ;
                else
                    alu.aluOp = mipsCtrlPkg::ALU_BLTZ; // rt 0 and rest
            end
            mipsCtrlPkg::OP_J, mipsCtrlPkg::OP_JAL: alu.aluOp = mipsCtrlPkg::ALU_J;
            default: ; // Undefined opcode stays NOP
        endcase
    end

    // Shamt path only ever feeds register shifts
    always_comb begin
        assert final (!alu.aluShift || fields.opcode == mipsCtrlPkg::OP_RTYPE)
            else $error("aluShift set for opcode %0h", fields.opcode);
    end

endmodule

//--- src/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               instrValid, // One instr per cycle while high
    input  logic [mipsCtrlPkg::instrWidth-1:0] instr,
    output logic                               ctrlValid,
    output mipsCtrlPkg::ctrlWord_t             ctrl
);

    mipsCtrlPkg::instrFields_t fields;   // Decoder inputs
    mipsCtrlPkg::aluCtrl_t     aluNext;
    mipsCtrlPkg::memCtrl_t     memNext;
    mipsCtrlPkg::flowCtrl_t    flowNext;
    mipsCtrlPkg::wbCtrl_t      wbNext;
    mipsCtrlPkg::ctrlWord_t    ctrlNext; // Combinational word into the stage flop

    // ==============================
    // Field split
    // ==============================
    assign fields.opcode = mipsCtrlPkg::opcode_e'(
        instr[mipsCtrlPkg::instrWidth-1 -: mipsCtrlPkg::fieldWidth]);     // [31:26]
    assign fields.rt     = instr[16 +: mipsCtrlPkg::regAddrWidth];        // [20:16]
    assign fields.funct  = mipsCtrlPkg::funct_e'(
        instr[mipsCtrlPkg::fieldWidth-1:0]);                              // [5:0]

    aluCtrlDecoder       uAluDec  (.fields(fields), .alu(aluNext));
    memCtrlDecoder       uMemDec  (.fields(fields), .mem(memNext));
    flowCtrlDecoder      uFlowDec (.fields(fields), .flow(flowNext));
    writebackCtrlDecoder uWbDec   (.fields(fields), .wb(wbNext));

    assign ctrlNext = '{alu: aluNext, mem: memNext, flow: flowNext, wb: wbNext};

    // ==============================
    // Decode/execute register
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= mipsCtrlPkg::nopWord; // Execute sees a bubble
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrl <= ctrlNext; // Hold last word through gaps
            end
        end
    end

    // No stale valid survives a reset
    assert property (@(posedge clk) !rstN |=> !ctrlValid)
        else $error("ctrlValid high after reset");

endmodule

//--- src/flowCtrlDecoder.sv
`timescale 1ns/100ps

module flowCtrlDecoder (
    input  mipsCtrlPkg::instrFields_t fields,
    output mipsCtrlPkg::flowCtrl_t    flow
);

    logic isRegJump; // JR or JALR funct

    assign isRegJump = (fields.funct == mipsCtrlPkg::FN_JR) ||
                       (fields.funct == mipsCtrlPkg::FN_JALR);

    always_comb begin
        flow = mipsCtrlPkg::nopWord.flow; // Sequential PC

        case (fields.opcode)
            // ==============================
            // Conditional branches
            // ==============================
            mipsCtrlPkg::OP_BEQ, mipsCtrlPkg::OP_BNE,
            mipsCtrlPkg::OP_BLEZ, mipsCtrlPkg::OP_BGTZ,
            mipsCtrlPkg::OP_REGIMM: begin
                flow.branch = 1'b1; // Taken decision from ALU
            end

            // Absolute 26-bit target
            mipsCtrlPkg::OP_J, mipsCtrlPkg::OP_JAL: begin
                flow.jump = 1'b1;
            end

            // Target from rs
            mipsCtrlPkg::OP_RTYPE: begin
                flow.jumpReg = isRegJump;
            end

            default: ; // Fall through to PC+4
        endcase
    end

    // Next-PC mux is one-hot or idle
    always_comb begin
        assert final ($onehot0({flow.branch, flow.jump, flow.jumpReg}))
            else $error("Multiple PC sources for opcode %0h", fields.opcode);
    end

endmodule

//--- src/memCtrlDecoder.sv
`timescale 1ns/100ps

module memCtrlDecoder (
    input  mipsCtrlPkg::instrFields_t fields,
    output mipsCtrlPkg::memCtrl_t     mem
);

    always_comb begin
        mem = mipsCtrlPkg::nopWord.mem; // No access, size WORD

        case (fields.opcode)
            // ==============================
            // Loads
            // ==============================
            mipsCtrlPkg::OP_LW: begin
                mem.memRead = 1'b1;
                mem.memSize = mipsCtrlPkg::SIZE_WORD;
            end
            mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH,
            mipsCtrlPkg::OP_LBU, mipsCtrlPkg::OP_LHU: begin
                mem.memRead    = 1'b1;
                mem.memSize    = mipsCtrlPkg::SIZE_WORD; // Full word, lane picked later
                mem.loadExtend = 1'b1;
                case (fields.opcode)
                    mipsCtrlPkg::OP_LH:  mem.loadType = mipsCtrlPkg::LD_LH;
                    mipsCtrlPkg::OP_LBU: mem.loadType = mipsCtrlPkg::LD_LBU; // Zero-fill
                    mipsCtrlPkg::OP_LHU: mem.loadType = mipsCtrlPkg::LD_LHU; // Zero-fill
                    default:             mem.loadType = mipsCtrlPkg::LD_LB;
                endcase
            end

            // ==============================
            // Stores
            // ==============================
            mipsCtrlPkg::OP_SW: begin
                mem.memWrite = 1'b1;
                mem.memSize  = mipsCtrlPkg::SIZE_WORD;
            end
            mipsCtrlPkg::OP_SH: begin
                mem.memWrite = 1'b1;
                mem.memSize  = mipsCtrlPkg::SIZE_HALF; // Two byte enables
            end
            mipsCtrlPkg::OP_SB: begin
                mem.memWrite = 1'b1;
                mem.memSize  = mipsCtrlPkg::SIZE_BYTE; // One byte enable
            end
            default: ; // Everything else leaves memory alone
        endcase
    end

    // Read and write port share one address
    always_comb begin
        assert final (!(mem.memRead && mem.memWrite))
            else $error("memRead and memWrite both set, opcode %0h", fields.opcode);
    end

endmodule

//--- src/mipsCtrlPkg.sv
package mipsCtrlPkg;

    // ==============================
    // Widths
    // ==============================
    localparam int instrWidth   = 32; // Full instruction word
    localparam int regAddrWidth = 5;  // rs/rt/rd index
    localparam int fieldWidth   = 6;  // Opcode and funct fields

    // ==============================
    // Instruction encodings
    // ==============================
    typedef enum logic [fieldWidth-1:0] {
        OP_RTYPE  = 6'b000000, // Decoded further by funct
        OP_REGIMM = 6'b000001, // BLTZ/BGEZ, picked by rt
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011, // Links to $ra
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000, // Immediate group 0x08..0x0f
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100, // Logical immediates zero-extend
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000, // Loads 0x20..0x25
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_LBU    = 6'b100100,
        OP_LHU    = 6'b100101,
        OP_SB     = 6'b101000, // Stores 0x28..0x2b
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcode_e;

    typedef enum logic [fieldWidth-1:0] {
        FN_SLL  = 6'b000000, // Shift amount from shamt
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001, // Writes PC+4 to rd
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // ALU function select, R-type codes equal funct
    typedef enum logic [fieldWidth-1:0] {
        ALU_SLL  = 6'b000000, // Also the idle code
        ALU_SRL  = 6'b000010,
        ALU_SRA  = 6'b000011,
        ALU_ADD  = 6'b100000,
        ALU_ADDU = 6'b100001,
        ALU_SUB  = 6'b100010,
        ALU_SUBU = 6'b100011,
        ALU_AND  = 6'b100100,
        ALU_OR   = 6'b100101,
        ALU_XOR  = 6'b100110,
        ALU_NOR  = 6'b100111,
        ALU_SLT  = 6'b101010,
        ALU_SLTU = 6'b101011,
        ALU_BLTZ = 6'b111000, // Branch/jump group, top bits 111
        ALU_BGEZ = 6'b111001,
        ALU_J    = 6'b111010,
        ALU_JR   = 6'b111011,
        ALU_BEQ  = 6'b111100,
        ALU_BNE  = 6'b111101,
        ALU_BLEZ = 6'b111110,
        ALU_BGTZ = 6'b111111
    } aluOp_e;

    // ==============================
    // Control field encodings
    // ==============================
    typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_RA = 2'd2} regDst_e;
    typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2} wbSel_e;
    typedef enum logic [1:0] {SIZE_BYTE = 2'd0, SIZE_HALF = 2'd1, SIZE_WORD = 2'd3} memSize_e;
    typedef enum logic [1:0] {LD_LB = 2'd0, LD_LH = 2'd1, LD_LBU = 2'd2, LD_LHU = 2'd3} loadType_e;

    typedef struct packed {
        opcode_e                 opcode; // instr[31:26]
        logic [regAddrWidth-1:0] rt;     // instr[20:16], REGIMM selector
        funct_e                  funct;  // instr[5:0]
    } instrFields_t;

    typedef struct packed {
        aluOp_e aluOp;
        logic   aluSrc;     // Immediate on operand B
        logic   aluShift;   // shamt on operand A
        logic   zeroExtend; // Zero- instead of sign-extend imm
        logic   lui;        // Imm shifted up by 16
    } aluCtrl_t;

    typedef struct packed {
        logic      memRead;
        logic      memWrite;
        memSize_e  memSize;
        loadType_e loadType;
        logic      loadExtend; // Sub-word load through extender
    } memCtrl_t;

    typedef struct packed {
        logic branch;  // Conditional, ALU resolves
        logic jump;    // J/JAL target
        logic jumpReg; // Target from rs
    } flowCtrl_t;

    typedef struct packed {
        logic    regWrite;
        regDst_e regDst;
        wbSel_e  wbSel;
    } wbCtrl_t;

    typedef struct packed {
        aluCtrl_t  alu;
        memCtrl_t  mem;
        flowCtrl_t flow;
        wbCtrl_t   wb;
    } ctrlWord_t;

    localparam aluOp_e aluNop = ALU_SLL; // Zero code, harmless with aluShift low

    // All-quiet word, only memSize non-zero
    localparam ctrlWord_t nopWord = '{
        alu:  '{aluOp: aluNop, aluSrc: 1'b0, aluShift: 1'b0, zeroExtend: 1'b0, lui: 1'b0},
        mem:  '{memRead: 1'b0, memWrite: 1'b0, memSize: SIZE_WORD, loadType: LD_LB,
                loadExtend: 1'b0},
        flow: '{branch: 1'b0, jump: 1'b0, jumpReg: 1'b0},
        wb:   '{regWrite: 1'b0, regDst: DST_RT, wbSel: WB_ALU}
    };

endpackage

//--- src/writebackCtrlDecoder.sv
`timescale 1ns/100ps

module writebackCtrlDecoder (
    input  mipsCtrlPkg::instrFields_t fields,
    output mipsCtrlPkg::wbCtrl_t      wb
);

    always_comb begin
        wb = mipsCtrlPkg::nopWord.wb; // No register write

        case (fields.opcode)
            // ==============================
            // Register-destination forms
            // ==============================
            mipsCtrlPkg::OP_RTYPE: begin
                if (fields.funct != mipsCtrlPkg::FN_JR) begin
                    wb.regWrite = 1'b1;
                    wb.regDst   = mipsCtrlPkg::DST_RD;
                end
                if (fields.funct == mipsCtrlPkg::FN_JALR)
                    wb.wbSel = mipsCtrlPkg::WB_PC4; // Return address into rd
            end

            // ALU result into rt
            mipsCtrlPkg::OP_ADDI, mipsCtrlPkg::OP_ADDIU,
            mipsCtrlPkg::OP_SLTI, mipsCtrlPkg::OP_SLTIU,
            mipsCtrlPkg::OP_ANDI, mipsCtrlPkg::OP_ORI,
            mipsCtrlPkg::OP_XORI, mipsCtrlPkg::OP_LUI: begin
                wb.regWrite = 1'b1;
                wb.regDst   = mipsCtrlPkg::DST_RT;
                wb.wbSel    = mipsCtrlPkg::WB_ALU;
            end

            // Load data into rt
            mipsCtrlPkg::OP_LW, mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH,
            mipsCtrlPkg::OP_LBU, mipsCtrlPkg::OP_LHU: begin
                wb.regWrite = 1'b1;
                wb.regDst   = mipsCtrlPkg::DST_RT;
                wb.wbSel    = mipsCtrlPkg::WB_MEM;
            end

            mipsCtrlPkg::OP_JAL: begin
                wb.regWrite = 1'b1;
                wb.regDst   = mipsCtrlPkg::DST_RA; // Hardwired $31
                wb.wbSel    = mipsCtrlPkg::WB_PC4;
            end
            default: ; // Stores, branches, J
        endcase
    end

    // $ra only ever receives a link address
    always_comb begin
        assert final (wb.regDst != mipsCtrlPkg::DST_RA || wb.wbSel == mipsCtrlPkg::WB_PC4)
            else $error("Write to $ra without PC+4, opcode %0h", fields.opcode);
    end

endmodule
